// ==== design/spio_pkt_pkg.sv ====
`default_nettype none

package spio_pkt_pkg;

	// Width of a long packet with payload
	localparam int PKT_LEN = 72;

	// Width of a short packet without payload
	localparam int SPKT_LEN = 40;

	// Header bit set when a 32 bit payload follows the key
	localparam int HDR_PAYLOAD_BIT = 1;

	// Header bit holding odd parity over all used packet bits
	localparam int HDR_PARITY_BIT = 0;

	// Long view with payload above key above header
	typedef struct packed {
		logic [PKT_LEN-SPKT_LEN-1:0] payload;
		logic [31:0]                 key;
		logic [7:0]                  hdr;
	} pkt_long_t;

	// Short view where only key and header are used
	typedef struct packed {
		logic [PKT_LEN-SPKT_LEN-1:0] unused;
		logic [31:0]                 key;
		logic [7:0]                  hdr;
	} pkt_short_t;

	// One packet word decoded either way
	typedef union packed {
		pkt_long_t  lng;
		pkt_short_t shrt;
	} pkt_u;

endpackage

`default_nettype wire

// ==== design/spio_uart_pkg.sv ====
`default_nettype none

package spio_uart_pkg;

	// Clock cycles per serial bit
	localparam int BAUD_DIV = 8;

	// Width of the bit period counter
	localparam int BAUD_CNT_W = $clog2(BAUD_DIV);

	// Start bit, eight data bits and stop bit
	localparam int FRAME_BITS = 10;

	// Byte that ends a sync sequence
	localparam logic [7:0] SYNC_BYTE = 8'hFF;

	// Filler byte sent ahead of the sync byte
	localparam logic [7:0] NULL_BYTE = 8'h00;

	// Null bytes per sync sequence
	localparam int SYNC_NULL_COUNT = 4;

endpackage

`default_nettype wire

// ==== design/spio_uart_tx_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module spio_uart_tx_control
	import spio_pkt_pkg::*;
	import spio_uart_pkg::*;
(
	input  wire               CLK_IN,
	input  wire               RESET_IN,
	input  wire [PKT_LEN-1:0] pkt_data_i,
	input  wire               pkt_vld_i,
	input  wire               sync_req_i,
	output logic              pkt_busy_o,
	output logic [7:0]        byte_data_o,
	output logic              byte_vld_o,
	input  wire               byte_busy_i
);

	// Sending nothing, a sync sequence or a packet
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_SYNC = 2'd1;
	localparam logic [1:0] ST_PKT  = 2'd2;

	logic [1:0]         state_q;
	logic [3:0]         byte_cnt_q;
	logic [3:0]         last_cnt_q;
	logic [PKT_LEN-1:0] pkt_sh_q;
	logic               issued_q;
	logic               sync_pend_q;
	logic               pkt_accept;
	pkt_u               pkt_in;

	// Incoming word seen through the packet views
	assign pkt_in = pkt_data_i;

	// Busy until the last frame is off the line or a sync is pending
	assign pkt_busy_o = (state_q != ST_IDLE) || byte_busy_i || issued_q || sync_pend_q;
	assign pkt_accept = pkt_vld_i && !pkt_busy_o;

	// UART busy rises one cycle late so issued_q covers that gap
	assign byte_vld_o = (state_q != ST_IDLE) && !byte_busy_i && !issued_q;

	// Packet bytes come out of the shifter, header byte first
	assign byte_data_o = (state_q == ST_PKT) ? pkt_sh_q[7:0] :
		((byte_cnt_q == 4'(SYNC_NULL_COUNT)) ? SYNC_BYTE : NULL_BYTE);

	//////////////////////////////
	// Control FSM
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
		begin
			// Link starts with a sync sequence
			state_q     <= ST_SYNC;
			byte_cnt_q  <= 4'd0;
			issued_q    <= 1'b0;
			sync_pend_q <= 1'b0;
		end
		else
		begin
			issued_q <= byte_vld_o;
			// Requests wait until the current transfer ends
			sync_pend_q <= sync_req_i || (sync_pend_q && (state_q != ST_IDLE));
			case (state_q)
				ST_IDLE:
					if (sync_pend_q)
					begin
						state_q    <= ST_SYNC;
						byte_cnt_q <= 4'd0;
					end
					else if (pkt_accept)
					begin
						state_q    <= ST_PKT;
						byte_cnt_q <= 4'd0;
					end
				ST_SYNC:
					if (byte_vld_o)
					begin
						if (byte_cnt_q == 4'(SYNC_NULL_COUNT))
							state_q <= ST_IDLE;
						else
							byte_cnt_q <= byte_cnt_q + 4'd1;
					end
				ST_PKT:
					if (byte_vld_o)
					begin
						if (byte_cnt_q == last_cnt_q)
							state_q <= ST_IDLE;
						else
							byte_cnt_q <= byte_cnt_q + 4'd1;
					end
				default:
					state_q <= ST_SYNC;
			endcase
		end
	end

	//////////////////////////////
	// Packet latch and byte shifter
	always_ff @(posedge CLK_IN)
	begin
		if (pkt_accept)
		begin
			pkt_sh_q <= pkt_data_i;
			// Index of the last byte, 9 bytes long or 5 short
			last_cnt_q <= pkt_in.lng.hdr[HDR_PAYLOAD_BIT] ? 4'(PKT_LEN / 8 - 1) :
				4'(SPKT_LEN / 8 - 1);
		end
		else if ((state_q == ST_PKT) && byte_vld_o)
			pkt_sh_q <= pkt_sh_q >> 8;
	end

	// No flow control so a packet offered while busy would be lost
	a_pkt_not_busy: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
		pkt_vld_i |-> !pkt_busy_o)
		else $error("packet offered while transmitter busy");

endmodule

`default_nettype wire

// ==== design/spio_uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module spio_uart_tx
	import spio_uart_pkg::*;
(
	input  wire       CLK_IN,
	input  wire       RESET_IN,
	input  wire [7:0] byte_data_i,
	input  wire       byte_vld_i,
	output logic      byte_busy_o,
	output logic      serial_o
);

	logic [BAUD_CNT_W-1:0] baud_cnt_q;
	logic [3:0]            bit_cnt_q;
	logic [8:0]            frame_q;
	logic                  baud_tick;
	logic                  last_bit;

	// End of the current bit period
	assign baud_tick = baud_cnt_q == BAUD_CNT_W'(BAUD_DIV - 1);
	// Stop bit is on the line
	assign last_bit = bit_cnt_q == 4'(FRAME_BITS - 1);

	//////////////////////////////
	// Bit timing and line driver
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
		begin
			byte_busy_o <= 1'b0;
			serial_o    <= 1'b1;
			baud_cnt_q  <= '0;
			bit_cnt_q   <= 4'd0;
		end
		else if (!byte_busy_o)
		begin
			// Start bit goes out right away
			if (byte_vld_i)
			begin
				byte_busy_o <= 1'b1;
				serial_o    <= 1'b0;
				baud_cnt_q  <= '0;
				bit_cnt_q   <= 4'd0;
			end
		end
		else if (baud_tick)
		begin
			baud_cnt_q <= '0;
			if (last_bit)
				byte_busy_o <= 1'b0;
			else
			begin
				bit_cnt_q <= bit_cnt_q + 4'd1;
				serial_o  <= frame_q[0];
			end
		end
		else
			baud_cnt_q <= baud_cnt_q + 1'b1;
	end

	// Data bits LSB first with the stop bit on top
	always_ff @(posedge CLK_IN)
	begin
		if (byte_vld_i && !byte_busy_o)
			frame_q <= {1'b1, byte_data_i};
		else if (byte_busy_o && baud_tick && !last_bit)
			frame_q <= frame_q >> 1;
	end

	// Control block must wait for busy to drop
	a_byte_not_busy: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
		byte_vld_i |-> !byte_busy_o)
		else $error("byte offered while UART transmitter busy");

endmodule

`default_nettype wire

// ==== design/spio_uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module spio_uart_rx
	import spio_uart_pkg::*;
(
	input  wire        CLK_IN,
	input  wire        RESET_IN,
	input  wire        serial_i,
	output logic [7:0] byte_data_o,
	output logic       byte_vld_o
);

	// Frame phases
	localparam logic [1:0] ST_IDLE  = 2'd0;
	localparam logic [1:0] ST_START = 2'd1;
	localparam logic [1:0] ST_DATA  = 2'd2;
	localparam logic [1:0] ST_STOP  = 2'd3;

	logic [1:0]            sync_q;
	logic                  line_d_q;
	logic                  line;
	logic [1:0]            state_q;
	logic [BAUD_CNT_W-1:0] baud_cnt_q;
	logic [2:0]            bit_cnt_q;
	logic [7:0]            shift_q;
	logic                  baud_tick;
	logic                  half_tick;

	// Synchronised line level
	assign line = sync_q[1];
	assign baud_tick = baud_cnt_q == BAUD_CNT_W'(BAUD_DIV - 1);
	// Middle of the start bit
	assign half_tick = baud_cnt_q == BAUD_CNT_W'(BAUD_DIV / 2 - 1);

	// Byte stays stable in the shifter while idle
	assign byte_data_o = shift_q;

	//////////////////////////////
	// Line synchroniser
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
		begin
			// Line idles high
			sync_q   <= 2'b11;
			line_d_q <= 1'b1;
		end
		else
		begin
			sync_q   <= {sync_q[0], serial_i};
			line_d_q <= line;
		end
	end

	//////////////////////////////
	// Frame FSM
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
		begin
			state_q    <= ST_IDLE;
			baud_cnt_q <= '0;
			bit_cnt_q  <= 3'd0;
			byte_vld_o <= 1'b0;
		end
		else
		begin
			byte_vld_o <= 1'b0;
			case (state_q)
				ST_IDLE:
				begin
					baud_cnt_q <= '0;
					// Falling edge may be a start bit
					if (!line && line_d_q)
						state_q <= ST_START;
				end
				ST_START:
					if (half_tick)
					begin
						// A glitch is high again at mid bit
						baud_cnt_q <= '0;
						bit_cnt_q  <= 3'd0;
						state_q    <= line ? ST_IDLE : ST_DATA;
					end
					else
						baud_cnt_q <= baud_cnt_q + 1'b1;
				ST_DATA:
					if (baud_tick)
					begin
						baud_cnt_q <= '0;
						bit_cnt_q  <= bit_cnt_q + 3'd1;
						if (bit_cnt_q == 3'd7)
							state_q <= ST_STOP;
					end
					else
						baud_cnt_q <= baud_cnt_q + 1'b1;
				default:
					if (baud_tick)
					begin
						// Low stop bit drops the byte
						state_q    <= ST_IDLE;
						byte_vld_o <= line;
					end
					else
						baud_cnt_q <= baud_cnt_q + 1'b1;
			endcase
		end
	end

	// Data bits sampled at bit centre, LSB first
	always_ff @(posedge CLK_IN)
	begin
		if ((state_q == ST_DATA) && baud_tick)
			shift_q <= {line, shift_q[7:1]};
	end

endmodule

`default_nettype wire

// ==== design/spio_uart_rx_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module spio_uart_rx_control
	import spio_pkt_pkg::*;
	import spio_uart_pkg::*;
(
	input  wire                CLK_IN,
	input  wire                RESET_IN,
	input  wire [7:0]          byte_data_i,
	input  wire                byte_vld_i,
	output logic [PKT_LEN-1:0] pkt_data_o,
	output logic               pkt_vld_o,
	output logic               synchronising_o
);

	// Header and body states double as byte index
	localparam logic [3:0] ST_HEAD  = 4'd0;
	localparam logic [3:0] ST_BODY0 = 4'd1;
	localparam logic [3:0] ST_BODY1 = 4'd2;
	localparam logic [3:0] ST_BODY2 = 4'd3;
	localparam logic [3:0] ST_BODY3 = 4'd4;
	// Payload bytes of long packets
	localparam logic [3:0] ST_BODY4 = 4'd5;
	localparam logic [3:0] ST_BODY5 = 4'd6;
	localparam logic [3:0] ST_BODY6 = 4'd7;
	localparam logic [3:0] ST_BODY7 = 4'd8;
	// One cycle parity check, bytes ignored here
	localparam logic [3:0] ST_VERIFY = 4'd9;
	// Waiting for the sync byte
	localparam logic [3:0] ST_SYNC = 4'd10;

	logic [3:0]         state_q;
	logic [PKT_LEN-1:0] pkt_q;
	pkt_u               pkt_view;
	logic               is_long;
	logic               parity_ok;

	assign pkt_view = pkt_q;
	assign is_long  = pkt_view.lng.hdr[HDR_PAYLOAD_BIT];

	// Odd parity over the bits the packet really uses
	assign parity_ok = is_long ? (^pkt_q) : (^{pkt_view.shrt.key, pkt_view.shrt.hdr});

	assign synchronising_o = state_q == ST_SYNC;

	//////////////////////////////
	// Packet FSM
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			state_q <= ST_SYNC;
		else
			case (state_q)
				ST_HEAD, ST_BODY0, ST_BODY1, ST_BODY2, ST_BODY4, ST_BODY5, ST_BODY6:
					if (byte_vld_i)
						state_q <= state_q + 4'd1;
				ST_BODY3:
					// Short packets end after the key
					if (byte_vld_i)
						state_q <= is_long ? ST_BODY4 : ST_VERIFY;
				ST_BODY7:
					if (byte_vld_i)
						state_q <= ST_VERIFY;
				ST_VERIFY:
					state_q <= parity_ok ? ST_HEAD : ST_SYNC;
				ST_SYNC:
					if (byte_vld_i && (byte_data_i == SYNC_BYTE))
						state_q <= ST_HEAD;
				default:
					state_q <= ST_SYNC;
			endcase
	end

	//////////////////////////////
	// Byte assembly
	always_ff @(posedge CLK_IN)
	begin
		if (byte_vld_i)
		begin
			// Header clears the word so short packets read zero above the key
			if (state_q == ST_HEAD)
				pkt_q <= {{(PKT_LEN - 8){1'b0}}, byte_data_i};
			else if (state_q <= ST_BODY7)
				pkt_q[{state_q, 3'b000} +: 8] <= byte_data_i;
		end
	end

	//////////////////////////////
	// Output register
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			pkt_vld_o <= 1'b0;
		else
			pkt_vld_o <= (state_q == ST_VERIFY) && parity_ok;
	end

	always_ff @(posedge CLK_IN)
	begin
		if (state_q == ST_VERIFY)
			pkt_data_o <= pkt_q;
	end

	// Verify cycle would miss a byte arriving right behind another
	a_byte_spacing: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
		byte_vld_i |=> !byte_vld_i)
		else $error("byte strobes in consecutive cycles");

endmodule

`default_nettype wire

// ==== design/spio_uart_link.sv ====
`timescale 1ns/1ps
`default_nettype none

module spio_uart_link
	import spio_pkt_pkg::*;
(
	input  wire                CLK_IN,
	input  wire                RESET_IN,
	input  wire [PKT_LEN-1:0]  pkt_tx_data_i,
	input  wire                pkt_tx_vld_i,
	input  wire                sync_req_i,
	output logic               pkt_tx_busy_o,
	output logic               serial_o,
	input  wire                serial_i,
	output logic [PKT_LEN-1:0] pkt_rx_data_o,
	output logic               pkt_rx_vld_o,
	output logic               synchronising_o
);

	// Transmit byte stream
	logic [7:0] tx_byte_data;
	logic       tx_byte_vld;
	logic       tx_byte_busy;

	// Receive byte stream
	logic [7:0] rx_byte_data;
	logic       rx_byte_vld;

	//////////////////////////////
	// Transmit path
	spio_uart_tx_control u_tx_control (
		.CLK_IN      (CLK_IN),
		.RESET_IN    (RESET_IN),
		.pkt_data_i  (pkt_tx_data_i),
		.pkt_vld_i   (pkt_tx_vld_i),
		.sync_req_i  (sync_req_i),
		.pkt_busy_o  (pkt_tx_busy_o),
		.byte_data_o (tx_byte_data),
		.byte_vld_o  (tx_byte_vld),
		.byte_busy_i (tx_byte_busy)
	);

	spio_uart_tx u_tx (
		.CLK_IN      (CLK_IN),
		.RESET_IN    (RESET_IN),
		.byte_data_i (tx_byte_data),
		.byte_vld_i  (tx_byte_vld),
		.byte_busy_o (tx_byte_busy),
		.serial_o    (serial_o)
	);

	//////////////////////////////
	// Receive path
	spio_uart_rx u_rx (
		.CLK_IN      (CLK_IN),
		.RESET_IN    (RESET_IN),
		.serial_i    (serial_i),
		.byte_data_o (rx_byte_data),
		.byte_vld_o  (rx_byte_vld)
	);

	spio_uart_rx_control u_rx_control (
		.CLK_IN          (CLK_IN),
		.RESET_IN        (RESET_IN),
		.byte_data_i     (rx_byte_data),
		.byte_vld_i      (rx_byte_vld),
		.pkt_data_o      (pkt_rx_data_o),
		.pkt_vld_o       (pkt_rx_vld_o),
		.synchronising_o (synchronising_o)
	);

endmodule

`default_nettype wire

// ==== verification/spio_uart_link_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module spio_uart_link_tb
	import spio_pkt_pkg::*;
	import spio_uart_pkg::*;
();

	// Cycles per serial frame and the limit for any single wait
	localparam int FRAME_CYCLES = FRAME_BITS * BAUD_DIV;
	localparam int WAIT_LIMIT   = 24 * FRAME_CYCLES;

	logic               CLK_IN = 1'b0;
	logic               RESET_IN;
	logic [PKT_LEN-1:0] pkt_tx_data;
	logic               pkt_tx_vld;
	logic               sync_req;
	logic               pkt_tx_busy;
	logic               serial_line;
	logic               serial_in;
	logic               line_flip;
	logic [PKT_LEN-1:0] pkt_rx_data;
	logic               pkt_rx_vld;
	logic               synchronising;
	logic [31:0]        lfsr_q;
	logic [PKT_LEN-1:0] expected_q[$];

	// Loopback where line_flip inverts the line for a chosen bit
	assign serial_in = serial_line ^ line_flip;

	spio_uart_link u_dut (
		.CLK_IN          (CLK_IN),
		.RESET_IN        (RESET_IN),
		.pkt_tx_data_i   (pkt_tx_data),
		.pkt_tx_vld_i    (pkt_tx_vld),
		.sync_req_i      (sync_req),
		.pkt_tx_busy_o   (pkt_tx_busy),
		.serial_o        (serial_line),
		.serial_i        (serial_in),
		.pkt_rx_data_o   (pkt_rx_data),
		.pkt_rx_vld_o    (pkt_rx_vld),
		.synchronising_o (synchronising)
	);

	// 20 ns clock
	always #10 CLK_IN = ~CLK_IN;

	//////////////////////////////
	// Random bits and reference model

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	// Shifts in one LFSR bit per step
	task automatic take_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsr_q = lfsr_step(lfsr_q);
			value  = {value[30:0], lfsr_q[0]};
		end
	endtask

	// Odd parity over the used bits means the receiver delivers it
	function automatic logic odd_parity(input logic [PKT_LEN-1:0] pkt);
		if (pkt[HDR_PAYLOAD_BIT])
			return ^pkt;
		return ^pkt[SPKT_LEN-1:0];
	endfunction

	// Short packets carry zeros above the key
	function automatic logic [PKT_LEN-1:0] make_packet(input logic is_long,
		input logic [5:0] hdr_rest, input logic [31:0] key, input logic [31:0] payload);
		logic [PKT_LEN-1:0] pkt;
		pkt = {(is_long ? payload : 32'h0), key, hdr_rest, 2'b00};
		pkt[HDR_PAYLOAD_BIT] = is_long;
		if (!odd_parity(pkt))
			pkt[HDR_PARITY_BIT] = 1'b1;
		return pkt;
	endfunction

	//////////////////////////////
	// Checks and waits
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_equal(input logic [PKT_LEN-1:0] actual,
		input logic [PKT_LEN-1:0] expected, input string what);
		if (actual !== expected)
			abort_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
				$time, what, actual, expected));
	endtask

	task automatic wait_tx_idle();
		int cycles;
		cycles = 0;
		while (pkt_tx_busy !== 1'b0)
		begin
			@(negedge CLK_IN);
			cycles++;
			if (cycles > WAIT_LIMIT)
				abort_run("Timed out waiting for the transmitter to become idle");
		end
	endtask

	task automatic wait_sync_level(input logic level);
		int cycles;
		cycles = 0;
		while (synchronising !== level)
		begin
			@(negedge CLK_IN);
			cycles++;
			if (cycles > WAIT_LIMIT)
				abort_run($sformatf("Timed out waiting for synchronising_o to go %0b", level));
		end
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (expected_q.size() != 0)
		begin
			@(negedge CLK_IN);
			cycles++;
			if (cycles > WAIT_LIMIT)
				abort_run("Timed out waiting for expected packets to arrive");
		end
	endtask

	// Offers one packet once the sender is idle
	task automatic send_packet(input logic [PKT_LEN-1:0] pkt, input logic expect_it);
		wait_tx_idle();
		pkt_tx_data = pkt;
		pkt_tx_vld  = 1'b1;
		if (expect_it && odd_parity(pkt))
			expected_q.push_back(pkt);
		@(negedge CLK_IN);
		pkt_tx_vld = 1'b0;
		// Sender stays busy while the accepted packet goes out
		check_equal(72'(pkt_tx_busy), 72'(1), "pkt_tx_busy_o after accept");
	endtask

	// Inverts data bit 0 of the next frame which is the header parity bit
	task automatic flip_next_frame_bit0();
		int cycles;
		cycles = 0;
		while (serial_line !== 1'b0)
		begin
			@(negedge CLK_IN);
			cycles++;
			if (cycles > WAIT_LIMIT)
				abort_run("Timed out waiting for a start bit on the serial line");
		end
		repeat (BAUD_DIV) @(negedge CLK_IN);
		line_flip = 1'b1;
		repeat (BAUD_DIV) @(negedge CLK_IN);
		line_flip = 1'b0;
	endtask

	//////////////////////////////
	// Monitor comparing every delivered packet in order
	always @(negedge CLK_IN)
	begin
		if (!RESET_IN && (pkt_rx_vld === 1'b1))
		begin
			if (expected_q.size() == 0)
				abort_run($sformatf("Packet %h delivered at %0t when none was expected",
					pkt_rx_data, $time));
			else
				check_equal(pkt_rx_data, expected_q.pop_front(), "received packet");
		end
	end

	//////////////////////////////
	// Stimulus
	initial
	begin
		logic [31:0] key;
		logic [31:0] payload;
		logic [31:0] hdr;
		logic [31:0] pick;
		RESET_IN    = 1'b1;
		pkt_tx_data = '0;
		pkt_tx_vld  = 1'b0;
		sync_req    = 1'b0;
		line_flip   = 1'b0;
		lfsr_q      = 32'h79d9_c364;
		repeat (4) @(negedge CLK_IN);
		RESET_IN = 1'b0;

		// Receiver waits for sync until the initial sequence lands
		check_equal(72'(synchronising), 72'(1), "synchronising_o after reset");
		wait_sync_level(1'b0);

		// Short packets including an all ones key
		send_packet(make_packet(1'b0, 6'h3F, 32'hFFFF_FFFF, 32'h0), 1'b1);
		for (int i = 0; i < 4; i++)
		begin
			take_bits(32, key);
			take_bits(6, hdr);
			send_packet(make_packet(1'b0, hdr[5:0], key, 32'h0), 1'b1);
		end
		wait_drain();

		// Long packets with payload
		send_packet(make_packet(1'b1, 6'h00, 32'h0, 32'hFFFF_FFFF), 1'b1);
		for (int i = 0; i < 4; i++)
		begin
			take_bits(32, key);
			take_bits(32, payload);
			take_bits(6, hdr);
			send_packet(make_packet(1'b1, hdr[5:0], key, payload), 1'b1);
		end
		wait_drain();

		// Header parity corrupted on the line so the packet is dropped
		take_bits(32, key);
		send_packet(make_packet(1'b0, 6'h15, key, 32'h0), 1'b0);
		flip_next_frame_bit0();
		wait_sync_level(1'b1);
		wait_tx_idle();
		sync_req = 1'b1;
		@(negedge CLK_IN);
		sync_req = 1'b0;
		wait_sync_level(1'b0);
		take_bits(32, key);
		take_bits(32, payload);
		send_packet(make_packet(1'b1, 6'h2A, key, payload), 1'b1);
		wait_drain();

		// Random mix of short and long
		for (int n = 0; n < 30; n++)
		begin
			take_bits(1, pick);
			take_bits(6, hdr);
			take_bits(32, key);
			payload = '0;
			if (pick[0])
				take_bits(32, payload);
			send_packet(make_packet(pick[0], hdr[5:0], key, payload), 1'b1);
		end
		wait_drain();

		// Quiet line afterwards so a stray delivery still shows
		repeat (2 * FRAME_CYCLES) @(negedge CLK_IN);
		if (expected_q.size() == 0)
		begin
			$display("No errors");
			$finish;
		end
		else
			abort_run($sformatf("%0d expected packets never arrived", expected_q.size()));
	end

endmodule

`default_nettype wire

// ==== build.f ====
design/spio_pkt_pkg.sv
design/spio_uart_pkg.sv
design/spio_uart_tx_control.sv
design/spio_uart_tx.sv
design/spio_uart_rx.sv
design/spio_uart_rx_control.sv
design/spio_uart_link.sv
verification/spio_uart_link_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the loopback simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module spio_uart_link_tb -f build.f -o spio_uart_link_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/spio_uart_link_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
	echo "SIMULATION FAILED"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi
echo "SIMULATION PASSED"
exit 0
